//--- hw/synth_consts.svh
`ifndef SYNTH_CONSTS_SVH
`define SYNTH_CONSTS_SVH

// slot geometry
`define SYN_VOICES      4
`define SYN_V_OSC       4   // oscs per voice
`define SYN_O_ENVS      2   // envs per osc, env 0 is amplitude

`define SYN_V_WIDTH     2
`define SYN_O_WIDTH     2
`define SYN_OE_WIDTH    1
`define SYN_SLOT_WIDTH  (`SYN_V_WIDTH + `SYN_O_WIDTH + `SYN_OE_WIDTH)

`define SYN_SLOTS       (`SYN_VOICES * `SYN_V_OSC * `SYN_O_ENVS)

// audio output
`define SYN_AUD_BIT_DEPTH  24

// slot on inputs to its term in the accumulator
`define SYN_MIX_LAT     3

// shift after the master volume multiply
`define SYN_VOL_SHIFT   4

`endif

//--- hw/synth_pkg.sv
`default_nettype none

package synth_pkg;

    // register group, taken from adr[6:5]
    typedef enum logic [1:0] {
        REG_OSC_LVL = 2'd0,  // per osc level
        REG_OSC_PAN = 2'd1,  // per osc pan
        REG_MASTER  = 2'd2,  // master volume
        REG_NONE    = 2'd3   // unmapped, writes dropped
    } reg_group_e;

    // what an envelope slot drives
    typedef enum logic {
        SLOT_AMP = 1'b0,  // env 0, summed into the mix
        SLOT_MOD = 1'b1   // env 1, modulation only
    } slot_kind_e;

endpackage

`default_nettype wire

//--- hw/slot_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

`include "synth_consts.svh"

module slot_sequencer (
    input  wire logic                        sCLK_XVXENVS,
    input  wire logic                        rst_n,
    input  wire logic [`SYN_SLOT_WIDTH-1:0]  xxxx,
    input  wire logic                        xxxx_zero,
    output logic      [`SYN_O_WIDTH-1:0]     osc_dly,
    output synth_pkg::slot_kind_e            kind_dly,
    output logic                             first_dly,
    output logic                             last_dly,
    output logic                             sync_lost
);

    localparam int LINE = `SYN_MIX_LAT - 1;  // depth to mixer stage 2

    logic [`SYN_SLOT_WIDTH-1:0]  slot_cnt;   // expected index of the current slot
    logic                        locked;     // seen a frame start since reset
    logic [`SYN_O_WIDTH-1:0]     osc_in;
    logic [`SYN_OE_WIDTH-1:0]    env_in;
    synth_pkg::slot_kind_e       kind_in;
    logic                        last_in;

    logic [`SYN_O_WIDTH-1:0]     osc_line   [LINE];
    synth_pkg::slot_kind_e       kind_line  [LINE];
    logic                        first_line [LINE];
    logic                        last_line  [LINE];

    // voice field sits in the top bits and is not needed here
    assign osc_in  = xxxx[`SYN_O_WIDTH+`SYN_OE_WIDTH-1:`SYN_OE_WIDTH];
    assign env_in  = xxxx[`SYN_OE_WIDTH-1:0];
    assign kind_in = (env_in == '0) ? synth_pkg::SLOT_AMP : synth_pkg::SLOT_MOD;
    assign last_in = (xxxx == (`SYN_SLOTS - 1));

    // frame alignment check
    always_ff @(posedge sCLK_XVXENVS or negedge rst_n) begin
        if (!rst_n) begin
            slot_cnt  <= '0;
            locked    <= 1'b0;
            sync_lost <= 1'b0;
        end else if (xxxx_zero) begin
            slot_cnt  <= 1;
            locked    <= 1'b1;
            sync_lost <= locked && (slot_cnt != '0);  // early or late frame start
        end else begin
            slot_cnt <= slot_cnt + 1'b1;
            if (locked && (slot_cnt == '0)) begin
                sync_lost <= 1'b1;  // wrapped without a start strobe
            end
        end
    end

    // carry fields down to the mixer
    always_ff @(posedge sCLK_XVXENVS or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < LINE; i++) begin
                osc_line[i]   <= '0;
                kind_line[i]  <= synth_pkg::SLOT_AMP;
                first_line[i] <= 1'b0;
                last_line[i]  <= 1'b0;
            end
        end else begin
            osc_line[0]   <= osc_in;
            kind_line[0]  <= kind_in;
            first_line[0] <= xxxx_zero;
            last_line[0]  <= last_in;
            for (int i = 1; i < LINE; i++) begin
                osc_line[i]   <= osc_line[i-1];
                kind_line[i]  <= kind_line[i-1];
                first_line[i] <= first_line[i-1];
                last_line[i]  <= last_line[i-1];
            end
        end
    end

    assign osc_dly   = osc_line[LINE-1];
    assign kind_dly  = kind_line[LINE-1];
    assign first_dly = first_line[LINE-1];
    assign last_dly  = last_line[LINE-1];

endmodule

`default_nettype wire

//--- hw/patch_regs.sv
`timescale 1ns/10ps
`default_nettype none

`include "synth_consts.svh"

module patch_regs (
    input  wire logic                        sCLK_XVXENVS,
    input  wire logic                        rst_n,
    input  wire logic [6:0]                  adr,
    input  wire logic [7:0]                  wdata,
    input  wire logic                        write,
    output logic      [`SYN_V_OSC*8-1:0]     osc_lvl,
    output logic      [`SYN_V_OSC*8-1:0]     osc_pan,
    output logic      [7:0]                  m_vol
);

    synth_pkg::reg_group_e       grp;
    logic [`SYN_O_WIDTH-1:0]     osc_sel;   // shared by all voices

    logic [7:0]  lvl_q [`SYN_V_OSC];
    logic [7:0]  pan_q [`SYN_V_OSC];
    logic [7:0]  vol_q;

    assign grp     = synth_pkg::reg_group_e'(adr[6:5]);
    assign osc_sel = adr[`SYN_O_WIDTH-1:0];

    // one register updated per write strobe
    always_ff @(posedge sCLK_XVXENVS or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `SYN_V_OSC; i++) begin
                lvl_q[i] <= '0;
                pan_q[i] <= '0;
            end
            vol_q <= '0;
        end else if (write) begin
            case (grp)
                synth_pkg::REG_OSC_LVL: begin
                    lvl_q[osc_sel] <= wdata;  // 0..127
                end
                synth_pkg::REG_OSC_PAN: begin
                    pan_q[osc_sel] <= wdata;  // 0 hard left, 127 near hard right
                end
                synth_pkg::REG_MASTER: begin
                    vol_q <= wdata;
                end
                synth_pkg::REG_NONE: begin
                    // unmapped group
                end
                default: begin
                end
            endcase
        end
    end

    // flatten for the mixer, osc 0 in the low byte
    genvar g;
    generate
        for (g = 0; g < `SYN_V_OSC; g++) begin : g_flat
            assign osc_lvl[g*8 +: 8] = lvl_q[g];
            assign osc_pan[g*8 +: 8] = pan_q[g];
        end
    endgenerate

    assign m_vol = vol_q;

endmodule

`default_nettype wire

//--- hw/vol_mixer.sv
`timescale 1ns/10ps
`default_nettype none

`include "synth_consts.svh"

module vol_mixer (
    input  wire logic                            sCLK_XVXENVS,
    input  wire logic                            rst_n,
    input  wire logic signed [16:0]              sine_lut_out,
    input  wire logic signed [7:0]               level_mul_vel,
    input  wire logic        [`SYN_O_WIDTH-1:0]  osc_dly,
    input  wire synth_pkg::slot_kind_e           kind_dly,
    input  wire logic                            first_dly,
    input  wire logic                            last_dly,
    input  wire logic                            sync_lost,
    input  wire logic        [`SYN_V_OSC*8-1:0]  osc_lvl,
    input  wire logic        [`SYN_V_OSC*8-1:0]  osc_pan,
    input  wire logic        [7:0]               m_vol,
    output logic signed [`SYN_AUD_BIT_DEPTH-1:0] lsound_out,
    output logic signed [`SYN_AUD_BIT_DEPTH-1:0] rsound_out,
    output logic                                 frame_valid
);

    localparam int AUD_W = `SYN_AUD_BIT_DEPTH;
    localparam int ACC_W = 32;         // 16 amp slots of 23 bits plus headroom
    localparam int VOL_W = ACC_W + 9;
    localparam logic signed [VOL_W-1:0] SAT_MAX = 2**(AUD_W-1) - 1;
    localparam logic signed [VOL_W-1:0] SAT_MIN = -(2**(AUD_W-1));

    logic signed [16:0]       in_sine;
    logic signed [7:0]        in_level;
    logic signed [24:0]       amp_full;
    logic signed [17:0]       s1_amp;
    logic        [7:0]        lvl_sel;
    logic        [7:0]        pan_sel;
    logic signed [8:0]        lvl_w;
    logic signed [9:0]        l_wt;
    logic signed [9:0]        r_wt;
    logic signed [26:0]       term_full;
    logic signed [19:0]       term;
    logic signed [29:0]       l_full;
    logic signed [29:0]       r_full;
    logic signed [22:0]       l_part;
    logic signed [22:0]       r_part;
    logic signed [ACC_W-1:0]  acc_l;
    logic signed [ACC_W-1:0]  acc_r;
    logic                     last_q;
    logic                     frm_ok;    // frame started in sync
    logic signed [8:0]        m_vol_w;
    logic signed [VOL_W-1:0]  vol_l;
    logic signed [VOL_W-1:0]  vol_r;
    logic                     vol_vld;

    function automatic logic signed [AUD_W-1:0] sat_aud(input logic signed [VOL_W-1:0] v);
        logic signed [VOL_W-1:0] s;
        s = v >>> `SYN_VOL_SHIFT;
        if (s > SAT_MAX) begin
            return SAT_MAX[AUD_W-1:0];
        end else if (s < SAT_MIN) begin
            return SAT_MIN[AUD_W-1:0];
        end
        return s[AUD_W-1:0];
    endfunction

    // stage 1, inputs registered then sample times level
    assign amp_full = in_sine * in_level;

    always_ff @(posedge sCLK_XVXENVS or negedge rst_n) begin
        if (!rst_n) begin
            in_sine  <= '0;
            in_level <= '0;
            s1_amp   <= '0;
        end else begin
            in_sine  <= sine_lut_out;
            in_level <= level_mul_vel;
            s1_amp   <= amp_full[24:7];  // >>> 7
        end
    end

    // stage 2, osc level and pan picked by the delayed osc field
    assign lvl_sel   = osc_lvl[osc_dly*8 +: 8];
    assign pan_sel   = osc_pan[osc_dly*8 +: 8];
    assign lvl_w     = $signed({1'b0, lvl_sel});
    assign r_wt      = $signed({2'b00, pan_sel});
    assign l_wt      = 10'sd128 - r_wt;
    assign term_full = s1_amp * lvl_w;
    assign term      = term_full[26:7];
    assign l_full    = term * l_wt;
    assign r_full    = term * r_wt;
    assign l_part    = l_full[29:7];
    assign r_part    = r_full[29:7];

    // stage 3, frame accumulators
    always_ff @(posedge sCLK_XVXENVS or negedge rst_n) begin
        if (!rst_n) begin
            acc_l  <= '0;
            acc_r  <= '0;
            last_q <= 1'b0;
            frm_ok <= 1'b0;
        end else begin
            last_q <= last_dly;
            if (first_dly) begin
                frm_ok <= !sync_lost;
            end
            if (kind_dly == synth_pkg::SLOT_AMP) begin
                if (first_dly) begin
                    acc_l <= ACC_W'(l_part);  // restart on slot 0
                    acc_r <= ACC_W'(r_part);
                end else begin
                    acc_l <= acc_l + l_part;
                    acc_r <= acc_r + r_part;
                end
            end else if (first_dly) begin
                acc_l <= '0;
                acc_r <= '0;
            end
        end
    end

    // stage 4, master volume on the finished totals
    assign m_vol_w = $signed({1'b0, m_vol});

    always_ff @(posedge sCLK_XVXENVS or negedge rst_n) begin
        if (!rst_n) begin
            vol_l <= '0;
            vol_r <= '0;
        end else if (last_q) begin
            vol_l <= acc_l * m_vol_w;
            vol_r <= acc_r * m_vol_w;
        end
    end

    // stage 5, shift, clamp and present
    always_ff @(posedge sCLK_XVXENVS or negedge rst_n) begin
        if (!rst_n) begin
            vol_vld     <= 1'b0;
            frame_valid <= 1'b0;
            lsound_out  <= '0;
            rsound_out  <= '0;
        end else begin
            vol_vld     <= last_q && frm_ok;
            frame_valid <= vol_vld;
            if (vol_vld) begin
                lsound_out <= sat_aud(vol_l);
                rsound_out <= sat_aud(vol_r);
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/mixer_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "synth_consts.svh"

module mixer_top (
    input  wire logic                            sCLK_XVXENVS,
    input  wire logic                            rst_n,
    input  wire logic        [`SYN_SLOT_WIDTH-1:0] xxxx,
    input  wire logic                            xxxx_zero,
    input  wire logic signed [16:0]              sine_lut_out,
    input  wire logic signed [7:0]               level_mul_vel,
    input  wire logic        [6:0]               adr,
    input  wire logic        [7:0]               wdata,
    input  wire logic                            write,
    output logic signed [`SYN_AUD_BIT_DEPTH-1:0] lsound_out,
    output logic signed [`SYN_AUD_BIT_DEPTH-1:0] rsound_out,
    output logic                                 frame_valid,
    output logic                                 sync_lost
);

    logic [`SYN_O_WIDTH-1:0]    osc_dly;
    synth_pkg::slot_kind_e      kind_dly;
    logic                       first_dly;
    logic                       last_dly;
    logic [`SYN_V_OSC*8-1:0]    osc_lvl;
    logic [`SYN_V_OSC*8-1:0]    osc_pan;
    logic [7:0]                 m_vol;

    slot_sequencer u_seq (
        .sCLK_XVXENVS (sCLK_XVXENVS),
        .rst_n        (rst_n),
        .xxxx         (xxxx),
        .xxxx_zero    (xxxx_zero),
        .osc_dly      (osc_dly),
        .kind_dly     (kind_dly),
        .first_dly    (first_dly),
        .last_dly     (last_dly),
        .sync_lost    (sync_lost)
    );

    patch_regs u_regs (
        .sCLK_XVXENVS (sCLK_XVXENVS),
        .rst_n        (rst_n),
        .adr          (adr),
        .wdata        (wdata),
        .write        (write),
        .osc_lvl      (osc_lvl),
        .osc_pan      (osc_pan),
        .m_vol        (m_vol)
    );

    vol_mixer u_mix (
        .sCLK_XVXENVS  (sCLK_XVXENVS),
        .rst_n         (rst_n),
        .sine_lut_out  (sine_lut_out),
        .level_mul_vel (level_mul_vel),
        .osc_dly       (osc_dly),
        .kind_dly      (kind_dly),
        .first_dly     (first_dly),
        .last_dly      (last_dly),
        .sync_lost     (sync_lost),   // gates output of an unaligned frame
        .osc_lvl       (osc_lvl),
        .osc_pan       (osc_pan),
        .m_vol         (m_vol),
        .lsound_out    (lsound_out),
        .rsound_out    (rsound_out),
        .frame_valid   (frame_valid)
    );

endmodule

`default_nettype wire

//--- testbench/tb_mixer.sv
`timescale 1ns/10ps
`default_nettype none

`include "synth_consts.svh"

module tb_mixer;

    localparam int FRAMES = 25;                          // frames sent over all tests
    localparam int LIMIT  = FRAMES * `SYN_SLOTS + 100;   // reset and drain fit in the margin
    localparam int FILL_ZERO = 0;
    localparam int FILL_RAND = 1;
    localparam int FILL_MOD  = 2;
    localparam int FILL_POS  = 3;
    localparam int FILL_NEG  = 4;

    logic                        sCLK_XVXENVS;
    logic                        rst_n;
    logic [`SYN_SLOT_WIDTH-1:0]  xxxx;
    logic                        xxxx_zero;
    logic signed [16:0]          sine_lut_out;
    logic signed [7:0]           level_mul_vel;
    logic [6:0]                  adr;
    logic [7:0]                  wdata;
    logic                        write;
    logic signed [23:0]          lsound_out;
    logic signed [23:0]          rsound_out;
    logic                        frame_valid;
    logic                        sync_lost;

    int           cyc = 0;
    bit           fv_prev = 1'b0;
    logic [31:0]  lfsr;
    int           err_total;
    int           tests_done;
    int           tests_passed;
    int           cur_test;
    int           test_err [1:6];
    logic signed [16:0]  fr_smp [`SYN_SLOTS];   // next frame's samples
    logic [6:0]          fr_lev [`SYN_SLOTS];
    int           m_lvl [`SYN_V_OSC];           // register model
    int           m_pan [`SYN_V_OSC];
    int           m_vol;
    logic [6:0]   wq_adr [$];                   // bus writes waiting for a slot
    logic [7:0]   wq_dat [$];
    logic [23:0]  q_l [$];                      // expected frames in flight
    logic [23:0]  q_r [$];
    int           q_due [$];
    int           q_test [$];
    bit           q_close [$];

    mixer_top u_dut (
        .sCLK_XVXENVS  (sCLK_XVXENVS),
        .rst_n         (rst_n),
        .xxxx          (xxxx),
        .xxxx_zero     (xxxx_zero),
        .sine_lut_out  (sine_lut_out),
        .level_mul_vel (level_mul_vel),
        .adr           (adr),
        .wdata         (wdata),
        .write         (write),
        .lsound_out    (lsound_out),
        .rsound_out    (rsound_out),
        .frame_valid   (frame_valid),
        .sync_lost     (sync_lost)
    );

    initial begin
        sCLK_XVXENVS = 1'b0;
        forever #2 sCLK_XVXENVS = ~sCLK_XVXENVS;
    end

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic string test_title(input int id);
        case (id)
            1: return "reset and zero patch";
            2: return "random frames back to back";
            3: return "mod slots and hard pan";
            4: return "saturation";
            5: return "sync loss and recovery";
            default: return "unmapped register write";
        endcase
    endfunction

    function automatic logic [23:0] clamp24(input longint v);
        if (v > 64'sd8388607) begin
            return 24'h7fffff;
        end else if (v < -64'sd8388608) begin
            return 24'h800000;
        end
        return v[23:0];
    endfunction

    task automatic flag_error(input int id);
        err_total++;
        test_err[id]++;
    endtask

    task automatic value_error(input string name, input logic [23:0] exp,
                               input logic [23:0] act, input int id);
        $display("ERROR %s expected 0x%06h got 0x%06h (cycle %0d)", name, exp, act, cyc);
        flag_error(id);
    endtask

    task automatic plain_error(input string what, input int id);
        $display("%s (cycle %0d)", what, cyc);
        flag_error(id);
    endtask

    // reference mix of the frame held in fr_smp and fr_lev
    task automatic model_frame(output logic [23:0] el, output logic [23:0] er);
        longint sl;
        longint sr;
        longint a;
        longint t;
        int     o;
        sl = 0;
        sr = 0;
        for (int s = 0; s < `SYN_SLOTS; s++) begin
            if (s % `SYN_O_ENVS == 0) begin   // amplitude slots only
                o = (s / `SYN_O_ENVS) % `SYN_V_OSC;
                a = (longint'(fr_smp[s]) * longint'(fr_lev[s])) >>> 7;
                t = (a * m_lvl[o]) >>> 7;
                sl += (t * (128 - m_pan[o])) >>> 7;
                sr += (t * m_pan[o]) >>> 7;
            end
        end
        el = clamp24((sl * m_vol) >>> `SYN_VOL_SHIFT);
        er = clamp24((sr * m_vol) >>> `SYN_VOL_SHIFT);
    endtask

    task automatic reg_write(input synth_pkg::reg_group_e grp, input int osc, input int val);
        wq_adr.push_back({grp, osc[4:0]});
        wq_dat.push_back(val[7:0]);
        case (grp)
            synth_pkg::REG_OSC_LVL: m_lvl[osc] = val;
            synth_pkg::REG_OSC_PAN: m_pan[osc] = val;
            synth_pkg::REG_MASTER:  m_vol = val;
            default: ;               // unmapped group
        endcase
    endtask

    task automatic fill_frame(input int mode);
        for (int s = 0; s < `SYN_SLOTS; s++) begin
            fr_lev[s] = 7'd127;
            case (mode)
                FILL_RAND: begin
                    fr_smp[s] = take_bits(17);
                    fr_lev[s] = take_bits(7);
                end
                FILL_MOD: fr_smp[s] = (s % 2 == 1) ? 17'h0ffff : 17'h0;  // env 1 only
                FILL_POS: fr_smp[s] = 17'h0ffff;
                FILL_NEG: fr_smp[s] = 17'h10000;
                default:  fr_smp[s] = 17'h0;
            endcase
        end
    endtask

    // drives one frame, pending bus writes go out from slot 4 on
    task automatic send_frame(input int n_slots, input bit sync_exp, input bit checked,
                              input bit closes);
        logic [23:0] el;
        logic [23:0] er;
        int          last_cyc;
        model_frame(el, er);
        for (int s = 0; s < n_slots; s++) begin
            @(posedge sCLK_XVXENVS);
            #0.5;
            xxxx          = s[`SYN_SLOT_WIDTH-1:0];
            xxxx_zero     = (s == 0);
            sine_lut_out  = fr_smp[s];
            level_mul_vel = {1'b0, fr_lev[s]};
            write         = 1'b0;
            if (s >= 4 && wq_adr.size() > 0) begin
                adr   = wq_adr.pop_front();
                wdata = wq_dat.pop_front();
                write = 1'b1;
            end
            if (s == 1) begin   // slot 0 has been seen by now
                assert (sync_lost == sync_exp)
                    else value_error("sync_lost", {23'b0, sync_exp}, {23'b0, sync_lost}, cur_test);
            end
            last_cyc = cyc;
        end
        if (checked) begin
            q_l.push_back(el);
            q_r.push_back(er);
            q_due.push_back(last_cyc + `SYN_MIX_LAT + 2);
            q_test.push_back(cur_test);
            q_close.push_back(closes);
        end
    endtask

    task automatic close_entry();
        int          id;
        bit          cl;
        void'(q_l.pop_front());
        void'(q_r.pop_front());
        void'(q_due.pop_front());
        id = q_test.pop_front();
        cl = q_close.pop_front();
        if (cl) begin
            tests_done++;
            if (test_err[id] == 0) begin
                tests_passed++;
            end
            $display("test %0d %s: %s, %0d errors", id, test_title(id),
                     (test_err[id] == 0) ? "ok" : "FAILED", test_err[id]);
        end
    endtask

    always @(posedge sCLK_XVXENVS) begin
        cyc <= cyc + 1;
        if (cyc >= LIMIT) begin
            $display("run stopped at cycle %0d with %0d frames outstanding", cyc, q_due.size());
            $display("sim failed");
            $finish;
        end else if (rst_n) begin
            fv_prev <= frame_valid;
            assert (!(frame_valid && fv_prev))
                else plain_error("frame_valid stayed high for two cycles", cur_test);
            if (frame_valid) begin
                assert (q_due.size() > 0 && q_due[0] == cyc)
                    else plain_error("frame_valid pulsed when no frame was due", cur_test);
                if (q_due.size() > 0 && q_due[0] == cyc) begin
                    assert (lsound_out == q_l[0])
                        else value_error("lsound_out", q_l[0], lsound_out, q_test[0]);
                    assert (rsound_out == q_r[0])
                        else value_error("rsound_out", q_r[0], rsound_out, q_test[0]);
                    close_entry();
                end
            end else if (q_due.size() > 0 && q_due[0] == cyc) begin
                assert (frame_valid)
                    else plain_error("frame_valid missing when its frame was due", q_test[0]);
                close_entry();
            end
        end
    end

    initial begin
        lfsr          = 32'hb744;
        err_total     = 0;
        tests_done    = 0;
        tests_passed  = 0;
        cur_test      = 1;
        m_vol         = 0;
        for (int i = 1; i <= 6; i++) begin
            test_err[i] = 0;
        end
        for (int o = 0; o < `SYN_V_OSC; o++) begin
            m_lvl[o] = 0;
            m_pan[o] = 0;
        end
        rst_n         = 1'b0;
        xxxx          = '0;
        xxxx_zero     = 1'b0;
        sine_lut_out  = '0;
        level_mul_vel = '0;
        adr           = '0;
        wdata         = '0;
        write         = 1'b0;
        repeat (10) @(posedge sCLK_XVXENVS);
        #0.5;
        rst_n = 1'b1;
        repeat (2) @(posedge sCLK_XVXENVS);

        assert (lsound_out == 0) else value_error("lsound_out", 24'h0, lsound_out, 1);
        assert (rsound_out == 0) else value_error("rsound_out", 24'h0, rsound_out, 1);
        assert (!frame_valid) else value_error("frame_valid", 24'h0, {23'b0, frame_valid}, 1);
        assert (!sync_lost) else value_error("sync_lost", 24'h0, {23'b0, sync_lost}, 1);
        fill_frame(FILL_RAND);
        send_frame(`SYN_SLOTS, 1'b0, 1'b1, 1'b1);   // patch still all zero

        cur_test = 2;
        for (int o = 0; o < `SYN_V_OSC; o++) begin
            reg_write(synth_pkg::REG_OSC_LVL, o, take_bits(7));
            reg_write(synth_pkg::REG_OSC_PAN, o, 64);
        end
        reg_write(synth_pkg::REG_MASTER, 0, 16);
        fill_frame(FILL_ZERO);
        send_frame(`SYN_SLOTS, 1'b0, 1'b1, 1'b0);
        for (int f = 0; f < 8; f++) begin
            fill_frame(FILL_RAND);
            send_frame(`SYN_SLOTS, 1'b0, 1'b1, f == 7);
        end

        cur_test = 3;
        for (int o = 0; o < `SYN_V_OSC; o++) begin
            reg_write(synth_pkg::REG_OSC_LVL, o, 127);
            reg_write(synth_pkg::REG_OSC_PAN, o, (o % 2 == 1) ? 127 : 0);  // hard left or right
        end
        reg_write(synth_pkg::REG_MASTER, 0, 16);
        fill_frame(FILL_ZERO);
        send_frame(`SYN_SLOTS, 1'b0, 1'b1, 1'b0);
        fill_frame(FILL_MOD);
        send_frame(`SYN_SLOTS, 1'b0, 1'b1, 1'b0);
        fill_frame(FILL_RAND);
        send_frame(`SYN_SLOTS, 1'b0, 1'b1, 1'b1);

        cur_test = 4;
        for (int o = 0; o < `SYN_V_OSC; o++) begin
            reg_write(synth_pkg::REG_OSC_PAN, o, 0);
        end
        reg_write(synth_pkg::REG_MASTER, 0, 255);
        for (int side = 0; side < 2; side++) begin
            fill_frame(FILL_ZERO);
            send_frame(`SYN_SLOTS, 1'b0, 1'b1, 1'b0);
            fill_frame(FILL_POS);
            send_frame(`SYN_SLOTS, 1'b0, 1'b1, 1'b0);
            fill_frame(FILL_NEG);
            send_frame(`SYN_SLOTS, 1'b0, 1'b1, side == 1);
            for (int o = 0; o < `SYN_V_OSC; o++) begin
                reg_write(synth_pkg::REG_OSC_PAN, o, 127);   // right side next
            end
        end

        cur_test = 5;
        fill_frame(FILL_RAND);
        send_frame(`SYN_SLOTS, 1'b0, 1'b1, 1'b0);
        fill_frame(FILL_RAND);
        send_frame(`SYN_SLOTS - 1, 1'b0, 1'b0, 1'b0);   // next start one slot early
        fill_frame(FILL_RAND);
        send_frame(`SYN_SLOTS, 1'b1, 1'b0, 1'b0);       // output suppressed
        fill_frame(FILL_RAND);
        send_frame(`SYN_SLOTS, 1'b0, 1'b1, 1'b1);

        cur_test = 6;
        for (int o = 0; o < `SYN_V_OSC; o++) begin
            reg_write(synth_pkg::REG_OSC_PAN, o, 64);
        end
        reg_write(synth_pkg::REG_MASTER, 0, 16);
        reg_write(synth_pkg::REG_NONE, 1, 0);
        reg_write(synth_pkg::REG_NONE, 3, 255);
        fill_frame(FILL_ZERO);
        send_frame(`SYN_SLOTS, 1'b0, 1'b1, 1'b0);
        fill_frame(FILL_RAND);
        send_frame(`SYN_SLOTS, 1'b0, 1'b1, 1'b1);

        @(posedge sCLK_XVXENVS);
        #0.5;
        xxxx          = '0;
        xxxx_zero     = 1'b0;
        sine_lut_out  = '0;
        level_mul_vel = '0;
        write         = 1'b0;
        while (q_due.size() > 0) begin
            @(posedge sCLK_XVXENVS);
        end
        repeat (4) @(posedge sCLK_XVXENVS);
        $display("%0d of 6 tests passed, %0d reported, %0d errors",
                 tests_passed, tests_done, err_total);
        if (err_total == 0 && tests_passed == 6) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+hw
hw/synth_pkg.sv
hw/slot_sequencer.sv
hw/patch_regs.sv
hw/vol_mixer.sv
hw/mixer_top.sv
testbench/tb_mixer.sv
